// File: design/fpFormatPkg.sv
package fpFormatPkg;

    //////////////////////////////////////////////////
    // Single-precision field widths
    //////////////////////////////////////////////////

    localparam int expWidth = 8;
    localparam int manWidth = 23;

    // Hidden one plus the stored mantissa
    localparam int sigWidth = manWidth + 1;

    //////////////////////////////////////////////////
    // Exponent encoding
    //////////////////////////////////////////////////

    localparam int expBias = 127;

    // All-ones exponent, reserved for infinity
    localparam int expMax = 255;

    //////////////////////////////////////////////////
    // Float word, seen as raw bits or as fields
    //////////////////////////////////////////////////

    typedef union packed {
        logic [expWidth+manWidth:0] raw;
        struct packed {
            logic                sign;
            logic [expWidth-1:0] exp;
            logic [manWidth-1:0] man;
        } fields;
    } floatWord;

endpackage

// File: design/koaCfgPkg.sv
package koaCfgPkg;

    // Operands this narrow go straight to a leaf multiplier
    localparam int defaultLeafWidth = 8;

    // Only the leaves are clocked, so the core takes one edge
    localparam int koaLatency = 1;

    // Operand stage, core, round stage
    localparam int pipeLatency = 3;

endpackage

// File: design/leafMult.sv
`timescale 1ns/1ps

module leafMult #(
    parameter int opWidth = 8
) (
    input  logic                 clk_i,
    input  logic [opWidth-1:0]   a_i,
    input  logic [opWidth-1:0]   b_i,
    output logic [2*opWidth-1:0] prod_o
);

    localparam int prodW = 2 * opWidth;

    // Plain product, widened before the multiply
    always_ff @(posedge clk_i) begin
        prod_o <= prodW'(a_i) * prodW'(b_i);
    end

endmodule

// File: design/recursiveKoa.sv
`timescale 1ns/1ps

module recursiveKoa #(
    parameter int opWidth   = 24,
    parameter int leafWidth = 8
) (
    input  logic                 clk_i,
    input  logic [opWidth-1:0]   a_i,
    input  logic [opWidth-1:0]   b_i,
    output logic [2*opWidth-1:0] prod_o
);

    generate
        if (opWidth <= leafWidth) begin : genLeaf

            // Bottom of the recursion
            leafMult #(
                .opWidth(opWidth)
            ) leafMult_i (
                .clk_i (clk_i),
                .a_i   (a_i),
                .b_i   (b_i),
                .prod_o(prod_o)
            );

        end else begin : genSplit

            //////////////////////////////////////////////////
            // Operand split
            //////////////////////////////////////////////////

            // Even width gives equal halves, odd width puts the extra bit low
            localparam int hiW   = opWidth / 2;
            localparam int loW   = opWidth - hiW;
            localparam int midW  = loW + 1;
            localparam int prodW = 2 * opWidth;

            logic [hiW-1:0]     aHi;
            logic [hiW-1:0]     bHi;
            logic [loW-1:0]     aLo;
            logic [loW-1:0]     bLo;
            logic [midW-1:0]    sumA;
            logic [midW-1:0]    sumB;
            logic [2*hiW-1:0]   qHigh;
            logic [2*loW-1:0]   qLow;
            logic [2*midW-1:0]  qMid;
            logic [prodW-1:0]   midTerm;

            assign aHi = a_i[opWidth-1:loW];
            assign bHi = b_i[opWidth-1:loW];
            assign aLo = a_i[loW-1:0];
            assign bLo = b_i[loW-1:0];

            // Half sums feed the middle multiplier, one bit wider than the low half
            assign sumA = midW'(aHi) + midW'(aLo);
            assign sumB = midW'(bHi) + midW'(bLo);

            //////////////////////////////////////////////////
            // Three sub-products
            //////////////////////////////////////////////////

            recursiveKoa #(
                .opWidth  (hiW),
                .leafWidth(leafWidth)
            ) koaHigh_i (
                .clk_i (clk_i),
                .a_i   (aHi),
                .b_i   (bHi),
                .prod_o(qHigh)
            );

            recursiveKoa #(
                .opWidth  (loW),
                .leafWidth(leafWidth)
            ) koaLow_i (
                .clk_i (clk_i),
                .a_i   (aLo),
                .b_i   (bLo),
                .prod_o(qLow)
            );

            recursiveKoa #(
                .opWidth  (midW),
                .leafWidth(leafWidth)
            ) koaMid_i (
                .clk_i (clk_i),
                .a_i   (sumA),
                .b_i   (sumB),
                .prod_o(qMid)
            );

            //////////////////////////////////////////////////
            // Recombine
            //////////////////////////////////////////////////

            // Cross terms aHi*bLo + aLo*bHi
            assign midTerm = prodW'(qMid) - prodW'(qHigh) - prodW'(qLow);

            assign prod_o = (prodW'(qHigh) << (2 * loW))
                          + (midTerm << loW)
                          + prodW'(qLow);

        end
    endgenerate

endmodule

// File: design/fpOperandStage.sv
`timescale 1ns/1ps

module fpOperandStage (
    input  logic                                   clk_i,
    input  logic                                   arstN_i,
    input  logic                                   valid_i,
    input  fpFormatPkg::floatWord                  opA_i,
    input  fpFormatPkg::floatWord                  opB_i,
    output logic [fpFormatPkg::sigWidth-1:0]       sigA_o,
    output logic [fpFormatPkg::sigWidth-1:0]       sigB_o,
    output logic                                   prodSign_o,
    output logic signed [fpFormatPkg::expWidth+1:0] expSum_o,
    output logic                                   isZero_o,
    output logic                                   valid_o
);

    // Two extra bits hold the carry and the sign of the unbiased sum
    localparam int expSW = fpFormatPkg::expWidth + 2;

    logic signed [expSW-1:0] expSumD;
    logic                    zeroD;

    always_comb begin
        expSumD = expSW'(opA_i.fields.exp) + expSW'(opB_i.fields.exp)
                - expSW'(fpFormatPkg::expBias);
        // Zero and denormal inputs both have a zero exponent
        zeroD = (opA_i.fields.exp == '0) || (opB_i.fields.exp == '0);
    end

    always_ff @(posedge clk_i or negedge arstN_i) begin
        if (!arstN_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
        end
    end

    // Payload
    always_ff @(posedge clk_i) begin
        sigA_o     <= {1'b1, opA_i.fields.man};
        sigB_o     <= {1'b1, opB_i.fields.man};
        prodSign_o <= opA_i.fields.sign ^ opB_i.fields.sign;
        expSum_o   <= expSumD;
        isZero_o   <= zeroD;
    end

endmodule

// File: design/fpRoundNorm.sv
`timescale 1ns/1ps

module fpRoundNorm (
    input  logic                                     clk_i,
    input  logic                                     arstN_i,
    input  logic                                     valid_i,
    input  logic [2*fpFormatPkg::sigWidth-1:0]       prod_i,
    input  logic                                     prodSign_i,
    input  logic signed [fpFormatPkg::expWidth+1:0]  expSum_i,
    input  logic                                     isZero_i,
    output logic                                     valid_o,
    output fpFormatPkg::floatWord                    result_o
);

    localparam int lat   = koaCfgPkg::koaLatency;
    localparam int expSW = fpFormatPkg::expWidth + 2;
    localparam int manW  = fpFormatPkg::manWidth;
    localparam int prodW = 2 * fpFormatPkg::sigWidth;

    logic [lat-1:0]          validPipe;
    logic [lat-1:0]          signPipe;
    logic [lat-1:0]          zeroPipe;
    logic signed [expSW-1:0] expPipe [lat];

    logic                    normHigh;
    logic [manW-1:0]         man;
    logic                    guard;
    logic                    sticky;
    logic                    roundUp;
    logic [manW:0]           manRounded;
    logic signed [expSW-1:0] expNorm;
    logic signed [expSW-1:0] expFinal;
    fpFormatPkg::floatWord   resultD;

    //////////////////////////////////////////////////
    // Side info waits for the core
    //////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge arstN_i) begin
        if (!arstN_i) begin
            validPipe <= '0;
        end else begin
            validPipe[0] <= valid_i;
            for (int i = 1; i < lat; i++) begin
                validPipe[i] <= validPipe[i-1];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        signPipe[0] <= prodSign_i;
        zeroPipe[0] <= isZero_i;
        expPipe[0]  <= expSum_i;
        for (int i = 1; i < lat; i++) begin
            signPipe[i] <= signPipe[i-1];
            zeroPipe[i] <= zeroPipe[i-1];
            expPipe[i]  <= expPipe[i-1];
        end
    end

    //////////////////////////////////////////////////
    // Normalize, round, pack
    //////////////////////////////////////////////////

    always_comb begin
        // Product of two [1,2) significands lies in [1,4)
        normHigh = prod_i[prodW-1];
        if (normHigh) begin
            man    = prod_i[prodW-2 -: manW];
            guard  = prod_i[prodW-2-manW];
            sticky = |prod_i[prodW-3-manW:0];
        end else begin
            man    = prod_i[prodW-3 -: manW];
            guard  = prod_i[prodW-3-manW];
            sticky = |prod_i[prodW-4-manW:0];
        end

        // Nearest, ties to even
        roundUp    = guard & (sticky | man[0]);
        manRounded = {1'b0, man} + (manW+1)'(roundUp);

        expNorm  = expPipe[lat-1] + expSW'(normHigh);
        // Carry out leaves an all-zero mantissa
        expFinal = expNorm + expSW'(manRounded[manW]);

        resultD.fields.sign = signPipe[lat-1];
        if (zeroPipe[lat-1] || expFinal <= 0) begin
            resultD.fields.exp = '0;
            resultD.fields.man = '0;
        end else if (expFinal >= fpFormatPkg::expMax) begin
            resultD.fields.exp = '1;
            resultD.fields.man = '0;
        end else begin
            resultD.fields.exp = expFinal[fpFormatPkg::expWidth-1:0];
            resultD.fields.man = manRounded[manW-1:0];
        end
    end

    always_ff @(posedge clk_i or negedge arstN_i) begin
        if (!arstN_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= validPipe[lat-1];
        end
    end

    always_ff @(posedge clk_i) begin
        result_o <= resultD;
    end

endmodule

// File: design/fpMulTop.sv
`timescale 1ns/1ps

module fpMulTop #(
    parameter int leafWidth = koaCfgPkg::defaultLeafWidth
) (
    input  logic        clk_i,
    input  logic        arstN_i,
    input  logic        valid_i,
    input  logic [31:0] opA_i,
    input  logic [31:0] opB_i,
    output logic        valid_o,
    output logic [31:0] result_o
);

    localparam int sigW  = fpFormatPkg::sigWidth;
    localparam int expSW = fpFormatPkg::expWidth + 2;

    logic [sigW-1:0]         sigA;
    logic [sigW-1:0]         sigB;
    logic [2*sigW-1:0]       prod;
    logic                    prodSign;
    logic signed [expSW-1:0] expSum;
    logic                    isZero;
    logic                    stageValid;

    // Decode and register operands
    fpOperandStage fpOperandStage_i (
        .clk_i     (clk_i),
        .arstN_i   (arstN_i),
        .valid_i   (valid_i),
        .opA_i     (opA_i),
        .opB_i     (opB_i),
        .sigA_o    (sigA),
        .sigB_o    (sigB),
        .prodSign_o(prodSign),
        .expSum_o  (expSum),
        .isZero_o  (isZero),
        .valid_o   (stageValid)
    );

    // Significand product
    recursiveKoa #(
        .opWidth  (sigW),
        .leafWidth(leafWidth)
    ) recursiveKoa_i (
        .clk_i (clk_i),
        .a_i   (sigA),
        .b_i   (sigB),
        .prod_o(prod)
    );

    fpRoundNorm fpRoundNorm_i (
        .clk_i     (clk_i),
        .arstN_i   (arstN_i),
        .valid_i   (stageValid),
        .prod_i    (prod),
        .prodSign_i(prodSign),
        .expSum_i  (expSum),
        .isZero_i  (isZero),
        .valid_o   (valid_o),
        .result_o  (result_o)
    );

endmodule

// File: verif/fpMul_checker.sv
`timescale 1ns/1ps

module fpMul_checker (
    input logic        clk_i,
    input logic        arstN_i,
    input logic        valid_i,
    input logic        valid_o,
    input logic [31:0] result_o
);

    fpFormatPkg::floatWord res;
    int                    assertFails = 0;

    assign res = result_o;

    validLatency: assert property (
        @(posedge clk_i) disable iff (!arstN_i)
        valid_o == $past(valid_i, koaCfgPkg::pipeLatency)
    ) else begin
        $error("valid_o does not follow valid_i by the pipeline latency");
        assertFails++;
    end

    resetQuiet: assert property (
        @(posedge clk_i) !arstN_i |-> !valid_o
    ) else begin
        $error("valid_o high during reset");
        assertFails++;
    end

    // Infinity is legal, a NaN pattern is not
    noNanOut: assert property (
        @(posedge clk_i) disable iff (!arstN_i)
        valid_o |-> !(res.fields.exp == fpFormatPkg::expMax && res.fields.man != '0)
    ) else begin
        $error("result has an all-ones exponent with a nonzero mantissa");
        assertFails++;
    end

endmodule

bind fpMulTop fpMul_checker fpMulChecker_i (
    .clk_i   (clk_i),
    .arstN_i (arstN_i),
    .valid_i (valid_i),
    .valid_o (valid_o),
    .result_o(result_o)
);

// File: verif/fpMulTb.sv
`timescale 1ns/1ps

module fpMulTb;

    localparam int clkPeriod    = 10;
    localparam int resetCycles  = 16;
    localparam int numRandom    = 200;
    localparam int numStream    = 64;
    localparam int numDirected  = 22;
    localparam int totalVectors = numRandom + numStream + numDirected;
    // Spaced vectors take two cycles, plus drain slack per test
    localparam int timeoutCycles = resetCycles + 2 * totalVectors + 200;

    logic        clk_i;
    logic        arstN_i;
    logic        valid_i;
    logic [31:0] opA_i;
    logic [31:0] opB_i;
    logic        valid_o;
    logic [31:0] result_o;

    int          seed;
    int          passCount;
    int          errCount;
    int          errMark;
    int          vecCount;
    logic [31:0] expQ [$];
    string       nameQ [$];
    time         timeQ [$];

    fpMulTop #(
        .leafWidth(8)
    ) fpMulTop_i (
        .clk_i   (clk_i),
        .arstN_i (arstN_i),
        .valid_i (valid_i),
        .opA_i   (opA_i),
        .opB_i   (opB_i),
        .valid_o (valid_o),
        .result_o(result_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(clkPeriod / 2) clk_i = ~clk_i;
    end

    //////////////////////////////////////////////////
    // Reference model and helpers
    //////////////////////////////////////////////////

    function automatic logic [31:0] refFpMul(input logic [31:0] a, input logic [31:0] b);
        logic        sign;
        int          expR;
        logic [47:0] sigA;
        logic [47:0] sigB;
        logic [47:0] prod;
        logic [22:0] man;
        logic        guard;
        logic        sticky;
        logic [23:0] manR;
        sign = a[31] ^ b[31];
        if (a[30:23] == 8'd0 || b[30:23] == 8'd0) begin
            return {sign, 31'd0};
        end
        sigA = {1'b1, a[22:0]};
        sigB = {1'b1, b[22:0]};
        prod = sigA * sigB;
        expR = int'(a[30:23]) + int'(b[30:23]) - 127;
        if (prod[47]) begin
            man    = prod[46:24];
            guard  = prod[23];
            sticky = |prod[22:0];
            expR   = expR + 1;
        end else begin
            man    = prod[45:23];
            guard  = prod[22];
            sticky = |prod[21:0];
        end
        manR = {1'b0, man} + 24'(guard && (sticky || man[0]));
        if (manR[23]) begin
            expR = expR + 1;
        end
        if (expR >= 255) begin
            return {sign, 8'hff, 23'd0};
        end
        if (expR <= 0) begin
            return {sign, 31'd0};
        end
        return {sign, expR[7:0], manR[22:0]};
    endfunction

    // Normal operand with exponent in [expLo, expHi]
    function automatic logic [31:0] randFloat(input int expLo, input int expHi);
        logic [31:0] r1;
        logic [31:0] r2;
        int          e;
        r1 = $random(seed);
        r2 = $random(seed);
        e  = expLo + (int'(r1[15:0]) % (expHi - expLo + 1));
        return {r1[31], e[7:0], r2[22:0]};
    endfunction

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (expected !== actual) begin
            $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
            errCount++;
        end else begin
            passCount++;
        end
    endtask

    task automatic drivePair(input string name, input logic [31:0] a, input logic [31:0] b);
        @(posedge clk_i);
        valid_i <= 1'b1;
        opA_i   <= a;
        opB_i   <= b;
        expQ.push_back(refFpMul(a, b));
        nameQ.push_back(name);
        timeQ.push_back($time);
        vecCount++;
    endtask

    task automatic idleCycle();
        @(posedge clk_i);
        valid_i <= 1'b0;
    endtask

    task automatic spacedPair(input string name, input logic [31:0] a, input logic [31:0] b);
        drivePair(name, a, b);
        idleCycle();
    endtask

    task automatic endTest(input string name);
        while (expQ.size() != 0) begin
            @(posedge clk_i);
        end
        $display("Test %s done: %0d vectors, %0d errors", name, vecCount, errCount - errMark);
        errMark  = errCount;
        vecCount = 0;
    endtask

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    initial begin : stimulus
        seed      = 60938;
        passCount = 0;
        errCount  = 0;
        errMark   = 0;
        vecCount  = 0;
        valid_i   = 1'b0;
        opA_i     = '0;
        opB_i     = '0;
        // Falling edge after time zero so the async reset fires
        arstN_i   = 1'b1;
        #2;
        arstN_i   = 1'b0;
        repeat (resetCycles) @(posedge clk_i);
        arstN_i <= 1'b1;
        repeat (2) @(posedge clk_i);

        spacedPair("exact", 32'h40400000, 32'h40a00000);
        spacedPair("exact", 32'h3fc00000, 32'h3fc00000);
        spacedPair("exact", 32'h40000000, 32'h3f000000);
        endTest("exact");

        spacedPair("sign", 32'h40400000, 32'h40a00000);
        spacedPair("sign", 32'hc0400000, 32'h40a00000);
        spacedPair("sign", 32'h40400000, 32'hc0a00000);
        spacedPair("sign", 32'hc0400000, 32'hc0a00000);
        endTest("sign");

        // Tie rounding up, tie kept even, sticky round, carry into exponent
        spacedPair("random", 32'h3fc00000, 32'h3f800001);
        spacedPair("random", 32'h3fc00000, 32'h3f800003);
        spacedPair("random", 32'h3fb504f3, 32'h3fb504f3);
        spacedPair("random", 32'h3ffffffe, 32'h3f800001);
        for (int i = 0; i < numRandom; i++) begin
            spacedPair("random", randFloat(64, 190), randFloat(64, 190));
        end
        endTest("random");

        spacedPair("zero", 32'h00000000, 32'h40400000);
        spacedPair("zero", 32'h80000000, 32'h40400000);
        spacedPair("zero", 32'h00000123, 32'hc0000000);
        spacedPair("zero", 32'h40400000, 32'h80400000);
        endTest("zero");

        spacedPair("range", 32'h7f000000, 32'h40000000);
        spacedPair("range", 32'hff7fffff, 32'h7f7fffff);
        spacedPair("range", 32'h7f7fffff, 32'h3f800001);
        spacedPair("range", 32'h00800000, 32'h3f000000);
        spacedPair("range", 32'h80800000, 32'h3f7fffff);
        spacedPair("range", 32'h1f800000, 32'h9f800000);
        spacedPair("range", 32'h00800000, 32'h40000000);
        endTest("range");

        for (int i = 0; i < numStream; i++) begin
            drivePair("stream", randFloat(1, 254), randFloat(1, 254));
        end
        idleCycle();
        endTest("stream");

        // Idle cycles after the last result, seen by the checker too
        repeat (koaCfgPkg::pipeLatency + 1) @(negedge clk_i);

        if (fpMulTop_i.fpMulChecker_i.assertFails != 0) begin
            $display("The checker saw %0d assertion failures",
                     fpMulTop_i.fpMulChecker_i.assertFails);
            errCount += fpMulTop_i.fpMulChecker_i.assertFails;
        end
        $display("Finished: %0d checks passed, %0d errors", passCount, errCount);
        if (errCount == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    //////////////////////////////////////////////////
    // Compare and watchdog
    //////////////////////////////////////////////////

    initial begin : compareResults
        int latency;
        forever begin
            @(posedge clk_i);
            if (valid_o === 1'b1) begin
                if (expQ.size() == 0) begin
                    $display("valid_o pulsed at %0t with no result outstanding", $time);
                    errCount++;
                end else begin
                    // DUT samples the pair one edge after it is driven
                    latency = int'(($time - timeQ[0]) / clkPeriod) - 1;
                    checkValue({nameQ[0], " result"}, expQ[0], result_o);
                    checkValue({nameQ[0], " latency"}, koaCfgPkg::pipeLatency, latency);
                    void'(expQ.pop_front());
                    void'(nameQ.pop_front());
                    void'(timeQ.pop_front());
                end
            end
        end
    end

    initial begin : watchdog
        #(timeoutCycles * clkPeriod);
        $display("Timeout after %0d cycles, results still outstanding: %0d",
                 timeoutCycles, expQ.size());
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

// File: vlog.f
design/fpFormatPkg.sv
design/koaCfgPkg.sv
design/leafMult.sv
design/recursiveKoa.sv
design/fpOperandStage.sv
design/fpRoundNorm.sv
design/fpMulTop.sv
verif/fpMul_checker.sv
verif/fpMulTb.sv

// File: Bender.yml
package:
  name: fpMul

sources:
  - design/fpFormatPkg.sv
  - design/koaCfgPkg.sv
  - design/leafMult.sv
  - design/recursiveKoa.sv
  - design/fpOperandStage.sv
  - design/fpRoundNorm.sv
  - design/fpMulTop.sv
  - target: simulation
    files:
      - verif/fpMul_checker.sv
      - verif/fpMulTb.sv
